// File: gb_pkg.sv
/*
 * handheld console system glue package
 * bus types, address map, interrupt vectors and select strobes
 */
package gb_pkg;

	typedef logic [15:0] addr_t;      // cpu address
	typedef logic [7:0]  data_t;      // bus byte
	typedef logic [4:0]  irq_bits_t;  // vblank, lcd, timer, serial, joypad
	typedef logic [14:0] wram_addr_t; // 32k work ram word
	typedef logic [6:0]  zp_addr_t;   // 127 byte zero page
	typedef logic [2:0]  wram_bank_t; // svbk bank number

	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  rd;
		logic  wr;
	} cpu_bus_t;

	// one strobe per block, address decode only
	typedef struct packed {
		logic joyp;
		logic if_reg;
		logic ie_reg;
		logic svbk;
		logic boot_off;
		logic wram;
		logic zpram;
		logic cart;
	} bus_sel_t;

	// --------------------
	// io registers
	localparam addr_t ADDR_JOYP     = 16'hFF00;
	localparam addr_t ADDR_IF       = 16'hFF0F;
	localparam addr_t ADDR_BOOT_OFF = 16'hFF50;
	localparam addr_t ADDR_SVBK     = 16'hFF70; // colour mode only
	localparam addr_t ADDR_IE       = 16'hFFFF;

	// --------------------
	// regions
	localparam addr_t CART_ROM_HI = 16'h7FFF; // rom starts at 0000
	localparam addr_t CART_RAM_LO = 16'hA000;
	localparam addr_t CART_RAM_HI = 16'hBFFF;
	localparam addr_t WRAM_LO     = 16'hC000;
	localparam addr_t WRAM_HI     = 16'hFDFF; // e000 up is the echo of c000
	localparam addr_t ZP_LO       = 16'hFF80;
	localparam addr_t ZP_HI       = 16'hFFFE;

	// --------------------
	// interrupts and defaults
	localparam data_t      IRQ_VEC_BASE    = 8'h40;
	localparam data_t      IRQ_VEC_STEP    = 8'd8;
	localparam data_t      IRQ_VEC_NONE    = 8'h55; // nothing pending
	localparam data_t      OPEN_BUS        = 8'hFF;
	localparam wram_bank_t WRAM_BANK_RESET = 3'd1;
	localparam addr_t      BOOT_END_DMG    = 16'h00FF;
	localparam addr_t      BOOT_END_CGB    = 16'h08FF;
	localparam addr_t      CART_HEADER_LO  = 16'h0100; // header window stays on cart
	localparam addr_t      CART_HEADER_HI  = 16'h01FF;

endpackage

// File: gb_bus_map.sv
/*
 * cpu address decode and read data mux
 * one strobe per region, vector wins during irq acknowledge
 */
module gb_bus_map import gb_pkg::*; (
	input  cpu_bus_t   cpu_bus,
	input  logic       irq_ack,
	input  logic       is_gbc,
	input  data_t      irq_vec,
	input  irq_bits_t  if_rdata,
	input  irq_bits_t  ie_rdata,
	input  data_t      joyp_rdata,
	input  wram_bank_t svbk_rdata,
	input  data_t      ram_rdata,
	input  data_t      rom_rdata,
	output bus_sel_t   sel,
	output data_t      cpu_rdata
);

	addr_t addr;

	assign addr = cpu_bus.addr;

	// --------------------
	// address decode
	always_comb begin
		sel          = '0;
		sel.joyp     = (addr == ADDR_JOYP);
		sel.if_reg   = (addr == ADDR_IF);
		sel.ie_reg   = (addr == ADDR_IE);
		sel.svbk     = (addr == ADDR_SVBK); // decoded in both modes
		sel.boot_off = (addr == ADDR_BOOT_OFF);
		sel.wram     = (addr >= WRAM_LO) && (addr <= WRAM_HI); // incl echo
		sel.zpram    = (addr >= ZP_LO) && (addr <= ZP_HI);
		sel.cart     = (addr <= CART_ROM_HI) ||
			((addr >= CART_RAM_LO) && (addr <= CART_RAM_HI));
	end

	// --------------------
	// read mux
	always_comb begin
		if (irq_ack)
			cpu_rdata = irq_vec;                 // ack cycle reads the vector
		else if (sel.if_reg)
			cpu_rdata = {3'b111, if_rdata};      // unused bits read high
		else if (sel.ie_reg)
			cpu_rdata = {3'b000, ie_rdata};
		else if (sel.svbk && is_gbc)
			cpu_rdata = {5'b11111, svbk_rdata};
		else if (sel.joyp)
			cpu_rdata = joyp_rdata;
		else if (sel.wram || sel.zpram)
			cpu_rdata = ram_rdata;               // registered in gb_wram
		else if (sel.cart)
			cpu_rdata = rom_rdata;               // boot rom or cartridge
		else
			cpu_rdata = OPEN_BUS;
	end

endmodule

// File: gb_irq_ctrl.sv
/*
 * interrupt controller, five fixed priority sources
 * IF and IE registers, vector generation, clear on end of acknowledge
 */
module gb_irq_ctrl import gb_pkg::*; (
	input  logic      clk_cpu,
	input  logic      reset,
	input  cpu_bus_t  cpu_bus,
	input  bus_sel_t  sel,
	input  logic      irq_ack,
	input  irq_bits_t irq_src,
	output logic      irq_n,
	output data_t     irq_vec,
	output irq_bits_t if_rdata,
	output irq_bits_t ie_rdata
);

	irq_bits_t if_r;      // pending flags
	irq_bits_t ie_r;      // enable mask
	irq_bits_t pending;
	irq_bits_t lowest;    // one hot, highest priority pending
	irq_bits_t if_next;
	logic      ack_d;     // irq_ack one cycle back
	logic      ack_fall;

	assign pending  = if_r & ie_r;
	assign lowest   = pending & (~pending + 5'd1); // isolate lowest set bit
	assign ack_fall = ack_d & ~irq_ack;

	assign irq_n    = ~|pending;
	assign if_rdata = if_r;
	assign ie_rdata = ie_r;

	// --------------------
	// vector
	always_comb begin
		irq_vec = IRQ_VEC_NONE;
		// walk down so bit 0 lands last and wins
		for (int i = 4; i >= 0; i--) begin
			if (pending[i])
				irq_vec = IRQ_VEC_BASE + IRQ_VEC_STEP * data_t'(i);
		end
	end

	// --------------------
	// flag update
	always_comb begin
		if_next = if_r | irq_src;      // source pulses set
		if (ack_fall)
			if_next = if_next & ~lowest; // serviced source cleared
		if (sel.if_reg && cpu_bus.wr)
			if_next = cpu_bus.wdata[4:0]; // cpu write overrides all
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r  <= '0;
			ie_r  <= '0;
			ack_d <= 1'b0;
		end else begin
			if_r  <= if_next;
			ack_d <= irq_ack;
			if (sel.ie_reg && cpu_bus.wr)
				ie_r <= cpu_bus.wdata[4:0];
		end
	end

endmodule

// File: gb_joypad.sv
/*
 * joypad matrix and edge interrupt
 * row select latch, active low lines, fall detect after two stage sampler
 */
module gb_joypad import gb_pkg::*; (
	input  logic     clk_cpu,
	input  logic     reset,
	input  cpu_bus_t cpu_bus,
	input  bus_sel_t sel,
	input  data_t    keys,       // active high pressed
	output data_t    joyp_rdata,
	output logic     joy_irq
);

	logic [1:0] row_sel;   // bit 0 directions, bit 1 buttons, low selects
	logic [3:0] lines;     // p10..p13, active low
	logic [3:0] line_d1;
	logic [3:0] line_d2;

	// both rows can pull a line low
	assign lines = ~((keys[3:0] & {4{~row_sel[0]}}) |
		(keys[7:4] & {4{~row_sel[1]}}));

	assign joyp_rdata = {2'b11, row_sel, lines};
	assign joy_irq    = |(line_d2 & ~line_d1); // any line high to low

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			row_sel <= 2'b11;      // nothing selected
			line_d1 <= 4'hF;
			line_d2 <= 4'hF;
		end else begin
			line_d1 <= lines;
			line_d2 <= line_d1;
			if (sel.joyp && cpu_bus.wr)
				row_sel <= cpu_bus.wdata[5:4];
		end
	end

endmodule

// File: gb_wram.sv
/*
 * work ram and zero page ram
 * 32k banked work ram via svbk in colour mode, 127 byte zero page,
 * registered read data
 */
module gb_wram import gb_pkg::*; (
	input  logic       clk_cpu,
	input  logic       reset,
	input  logic       is_gbc,
	input  cpu_bus_t   cpu_bus,
	input  bus_sel_t   sel,
	output data_t      ram_rdata,
	output wram_bank_t svbk_rdata
);

	data_t      wram_mem [0:32767];
	data_t      zp_mem   [0:126];
	wram_bank_t bank;
	wram_addr_t wram_addr;
	zp_addr_t   zp_addr;
	wram_bank_t bank_wdata;

	// c000 half is fixed bank 0, d000 half follows svbk
	assign wram_addr = cpu_bus.addr[12] ?
		{bank, cpu_bus.addr[11:0]} : {3'd0, cpu_bus.addr[11:0]};
	assign zp_addr    = cpu_bus.addr[6:0];   // ff80 -> 0
	assign bank_wdata = cpu_bus.wdata[2:0];
	assign svbk_rdata = bank;

	// --------------------
	// bank register
	always_ff @(posedge clk_cpu) begin
		if (reset)
			bank <= WRAM_BANK_RESET;
		else if (sel.svbk && cpu_bus.wr && is_gbc) begin
			if (bank_wdata == 3'd0)
				bank <= 3'd1;        // bank 0 not selectable here
			else
				bank <= bank_wdata;
		end
	end

	// --------------------
	// ram arrays
	always_ff @(posedge clk_cpu) begin
		if (sel.wram && cpu_bus.wr)
			wram_mem[wram_addr] <= cpu_bus.wdata;
		if (sel.zpram && cpu_bus.wr)
			zp_mem[zp_addr] <= cpu_bus.wdata;
	end

	// read data one cycle after address
	always_ff @(posedge clk_cpu) begin
		if (sel.zpram)
			ram_rdata <= zp_mem[zp_addr];
		else
			ram_rdata <= wram_mem[wram_addr];
	end

endmodule

// File: gb_boot_overlay.sv
/*
 * boot rom overlay on the cartridge bus
 * enable cleared by ff50 write, steers low rom reads to the boot port
 */
module gb_boot_overlay import gb_pkg::*; (
	input  logic        clk_cpu,
	input  logic        reset,
	input  logic        is_gbc,
	input  cpu_bus_t    cpu_bus,
	input  bus_sel_t    sel,
	input  data_t       boot_rdata,
	input  data_t       cart_rdata,
	output logic [11:0] boot_addr,
	output addr_t       cart_addr,
	output logic        cart_rd,
	output logic        cart_wr,
	output data_t       cart_wdata,
	output data_t       rom_rdata
);

	logic  boot_en;
	logic  boot_off_hit;
	logic  in_header;
	logic  boot_hit;
	addr_t boot_end;

	// dmg wants bit 0 set, cgb wants exactly 11
	assign boot_off_hit = is_gbc ? (cpu_bus.wdata == 8'h11) : cpu_bus.wdata[0];

	assign boot_end  = is_gbc ? BOOT_END_CGB : BOOT_END_DMG;
	assign in_header = is_gbc && (cpu_bus.addr >= CART_HEADER_LO) &&
		(cpu_bus.addr <= CART_HEADER_HI);   // cgb boot rom has a hole here
	assign boot_hit  = sel.cart && boot_en && (cpu_bus.addr <= boot_end) && !in_header;

	// cartridge port follows the cpu
	assign cart_addr  = cpu_bus.addr;
	assign cart_wdata = cpu_bus.wdata;
	assign cart_rd    = sel.cart && cpu_bus.rd && !boot_hit;
	assign cart_wr    = sel.cart && cpu_bus.wr;   // mbc writes pass through

	assign boot_addr = cpu_bus.addr[11:0];
	assign rom_rdata = boot_hit ? boot_rdata : cart_rdata;

	always_ff @(posedge clk_cpu) begin
		if (reset)
			boot_en <= 1'b1;       // boot rom mapped from reset
		else if (sel.boot_off && cpu_bus.wr && boot_off_hit)
			boot_en <= 1'b0;       // one way until next reset
	end

endmodule

// File: gb_sys_bus.sv
/*
 * system bus top level
 * cpu bus, cartridge, boot rom and joypad ports around the glue blocks
 */
module gb_sys_bus import gb_pkg::*; (
	input  logic        clk_cpu,
	input  logic        reset,
	input  logic        is_gbc,
	input  cpu_bus_t    cpu_bus,
	input  logic        irq_ack,
	input  logic [3:0]  irq_src_ext,   // vblank, lcd, timer, serial
	input  data_t       keys,
	input  data_t       boot_rdata,
	input  data_t       cart_rdata,
	output data_t       cpu_rdata,
	output logic        irq_n,
	output logic [11:0] boot_addr,
	output addr_t       cart_addr,
	output logic        cart_rd,
	output logic        cart_wr,
	output data_t       cart_wdata
);

	bus_sel_t   sel;
	irq_bits_t  irq_src;
	irq_bits_t  if_rdata;
	irq_bits_t  ie_rdata;
	data_t      irq_vec;
	data_t      joyp_rdata;
	data_t      ram_rdata;
	data_t      rom_rdata;
	wram_bank_t svbk_rdata;
	logic       joy_irq;

	assign irq_src = {joy_irq, irq_src_ext}; // joypad is bit 4

	// --------------------
	// decode and read mux
	gb_bus_map u_bus_map (
		.cpu_bus    (cpu_bus),
		.irq_ack    (irq_ack),
		.is_gbc     (is_gbc),
		.irq_vec    (irq_vec),
		.if_rdata   (if_rdata),
		.ie_rdata   (ie_rdata),
		.joyp_rdata (joyp_rdata),
		.svbk_rdata (svbk_rdata),
		.ram_rdata  (ram_rdata),
		.rom_rdata  (rom_rdata),
		.sel        (sel),
		.cpu_rdata  (cpu_rdata)
	);

	gb_irq_ctrl u_irq_ctrl (
		.clk_cpu  (clk_cpu),
		.reset    (reset),
		.cpu_bus  (cpu_bus),
		.sel      (sel),
		.irq_ack  (irq_ack),
		.irq_src  (irq_src),
		.irq_n    (irq_n),
		.irq_vec  (irq_vec),
		.if_rdata (if_rdata),
		.ie_rdata (ie_rdata)
	);

	gb_joypad u_joypad (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.cpu_bus    (cpu_bus),
		.sel        (sel),
		.keys       (keys),
		.joyp_rdata (joyp_rdata),
		.joy_irq    (joy_irq)
	);

	// --------------------
	// memories and cartridge side
	gb_wram u_wram (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.is_gbc     (is_gbc),
		.cpu_bus    (cpu_bus),
		.sel        (sel),
		.ram_rdata  (ram_rdata),
		.svbk_rdata (svbk_rdata)
	);

	gb_boot_overlay u_boot_overlay (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.is_gbc     (is_gbc),
		.cpu_bus    (cpu_bus),
		.sel        (sel),
		.boot_rdata (boot_rdata),
		.cart_rdata (cart_rdata),
		.boot_addr  (boot_addr),
		.cart_addr  (cart_addr),
		.cart_rd    (cart_rd),
		.cart_wr    (cart_wr),
		.cart_wdata (cart_wdata),
		.rom_rdata  (rom_rdata)
	);

endmodule

// File: tb_gb_sys_bus.sv
/*
 * directed testbench for the console system bus glue
 * plays the cpu, the boot rom and the cartridge
 */
module tb_gb_sys_bus import gb_pkg::*; ();

	logic        clk_cpu;
	logic        reset;
	logic        is_gbc;
	logic        irq_ack;
	cpu_bus_t    cpu_bus;
	logic [3:0]  irq_src_ext;   // vblank, lcd, timer, serial
	data_t       keys;
	data_t       boot_rdata;
	data_t       cart_rdata;
	data_t       cpu_rdata;
	data_t       cart_wdata;
	logic        irq_n;
	logic        cart_rd;
	logic        cart_wr;
	logic [11:0] boot_addr;
	addr_t       cart_addr;
	logic        rd_cart_seen;  // cart_rd during the last read
	logic        wr_cart_seen;  // cart_wr during the last write
	addr_t       wr_cart_addr;  // cart_addr during the last write
	data_t       wr_cart_data;  // cart_wdata during the last write
	data_t       ram_exp [0:255];
	data_t       zp_exp  [0:126];

	// boot rom and cartridge models
	assign boot_rdata = ~boot_addr[7:0];
	assign cart_rdata = cart_addr[7:0] ^ 8'hA5;

	gb_sys_bus DUT (
		.clk_cpu     (clk_cpu),
		.reset       (reset),
		.is_gbc      (is_gbc),
		.cpu_bus     (cpu_bus),
		.irq_ack     (irq_ack),
		.irq_src_ext (irq_src_ext),
		.keys        (keys),
		.boot_rdata  (boot_rdata),
		.cart_rdata  (cart_rdata),
		.cpu_rdata   (cpu_rdata),
		.irq_n       (irq_n),
		.boot_addr   (boot_addr),
		.cart_addr   (cart_addr),
		.cart_rd     (cart_rd),
		.cart_wr     (cart_wr),
		.cart_wdata  (cart_wdata)
	);

	initial clk_cpu = 1'b0;
	always #5 clk_cpu = ~clk_cpu;

	// --------------------
	// checking
	task check(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("Error at time %0t: %s is %02h, expected %02h", $time, name, got, exp);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task timeout_fail(input string what);
		$display("timed out waiting for %s", what);
		$display("tests failed");
		$fatal(1, "wait timeout");
	endtask

	// --------------------
	// cpu side bus cycles
	task bus_write(input addr_t a, input data_t d);
		@(posedge clk_cpu);
		cpu_bus.addr  <= a;
		cpu_bus.wdata <= d;
		cpu_bus.rd    <= 1'b0;
		cpu_bus.wr    <= 1'b1;
		@(negedge clk_cpu);
		wr_cart_seen = cart_wr;
		wr_cart_addr = cart_addr;
		wr_cart_data = cart_wdata;
		@(posedge clk_cpu);         // write lands here
		cpu_bus.wr <= 1'b0;
	endtask

	task bus_read(input addr_t a, output data_t d);
		@(posedge clk_cpu);
		cpu_bus.addr <= a;
		cpu_bus.rd   <= 1'b1;
		cpu_bus.wr   <= 1'b0;
		@(posedge clk_cpu);         // ram data registered here
		@(negedge clk_cpu);
		d = cpu_rdata;
		rd_cart_seen = cart_rd;
		@(posedge clk_cpu);
		cpu_bus.rd <= 1'b0;
	endtask

	task irq_acknowledge(output data_t vec);
		@(posedge clk_cpu);
		irq_ack <= 1'b1;
		@(negedge clk_cpu);
		vec = cpu_rdata;
		@(posedge clk_cpu);
		irq_ack <= 1'b0;
		@(posedge clk_cpu);         // flag clear edge
	endtask

	task wait_irq_low;
		int n;
		n = 0;
		do begin
			@(negedge clk_cpu);
			n++;
		end while (irq_n !== 1'b0 && n < 20);
		if (irq_n !== 1'b0)
			timeout_fail("irq_n to fall");
	endtask

	// --------------------
	// tests
	task after_reset_state;
		data_t d;
		@(negedge clk_cpu);
		check("irq_n", data_t'(irq_n), 8'd1);
		bus_read(ADDR_IF, d);
		check("IF", d, 8'hE0);       // upper bits read high
		bus_read(ADDR_IE, d);
		check("IE", d, 8'h00);
		bus_read(ADDR_JOYP, d);
		check("JOYP select", data_t'(d[5:4]), 8'd3);
		bus_read(16'hFF03, d);
		check("open bus", d, OPEN_BUS);
		bus_read(ADDR_SVBK, d);
		check("SVBK", d, 8'hF9);     // bank 1
	endtask

	task ram_readback;
		data_t d;
		data_t va;
		for (int i = 0; i < 256; i++) begin
			ram_exp[i] = data_t'($urandom);
			bus_write(WRAM_LO + addr_t'(i), ram_exp[i]);
		end
		for (int i = 0; i < 127; i++) begin
			zp_exp[i] = data_t'($urandom);
			bus_write(ZP_LO + addr_t'(i), zp_exp[i]);
		end
		for (int i = 0; i < 256; i++) begin
			bus_read(WRAM_LO + addr_t'(i), d);
			check("wram", d, ram_exp[i]);
		end
		for (int i = 0; i < 127; i++) begin
			bus_read(ZP_LO + addr_t'(i), d);
			check("zero page", d, zp_exp[i]);
		end
		va = data_t'($urandom);
		bus_write(16'hE000, va);    // echo region
		bus_read(WRAM_LO, d);
		check("wram echo", d, va);
		// banked half
		bus_write(ADDR_SVBK, 8'd2);
		bus_write(16'hD000, va);
		bus_write(ADDR_SVBK, 8'd5);
		bus_write(16'hD000, ~va);
		bus_read(16'hD000, d);
		check("wram bank 5", d, ~va);
		bus_write(ADDR_SVBK, 8'd2);
		bus_read(16'hD000, d);
		check("wram bank 2", d, va);
		bus_write(ADDR_SVBK, 8'd0);   // stores 1
		bus_read(ADDR_SVBK, d);
		check("SVBK zero write", d, 8'hF9);
	endtask

	task irq_priority;
		data_t d;
		bus_write(ADDR_IE, 8'h1F);
		@(posedge clk_cpu);
		irq_src_ext <= 4'b0110;     // lcd and timer together
		@(posedge clk_cpu);
		irq_src_ext <= 4'b0000;
		wait_irq_low;
		irq_acknowledge(d);
		check("vector lcd", d, 8'h48);
		bus_read(ADDR_IF, d);
		check("IF after lcd ack", d, 8'hE4);
		irq_acknowledge(d);
		check("vector timer", d, 8'h50);
		@(negedge clk_cpu);
		check("irq_n idle", data_t'(irq_n), 8'd1);
		irq_acknowledge(d);
		check("vector none", d, IRQ_VEC_NONE);
	endtask

	task joypad_matrix;
		data_t d;
		int    n;
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_JOYP, 8'h20);  // direction row
		@(posedge clk_cpu);
		keys <= 8'h08;                // down
		n = 0;
		d = 8'h00;
		while (!d[4] && n < 10) begin
			bus_read(ADDR_IF, d);
			n++;
		end
		if (!d[4])
			timeout_fail("joypad interrupt flag");
		bus_read(ADDR_JOYP, d);
		check("JOYP down", d, 8'hE7);
		@(posedge clk_cpu);
		keys <= 8'h10;                // A, row not selected
		bus_read(ADDR_JOYP, d);
		check("JOYP button unselected", d, 8'hEF);
		@(posedge clk_cpu);
		keys <= 8'h00;
	endtask

	task boot_overlay_steer;
		data_t d;
		bus_read(16'h0042, d);
		check("boot read", d, 8'hBD);
		check("cart_rd boot", data_t'(rd_cart_seen), 8'd0);
		bus_read(16'h0150, d);        // header hole in colour mode
		check("header read", d, 8'hF5);
		check("cart_rd header", data_t'(rd_cart_seen), 8'd1);
		bus_write(ADDR_BOOT_OFF, 8'h11);
		bus_read(16'h0042, d);
		check("cart read", d, 8'hE7);
		check("cart_rd cart", data_t'(rd_cart_seen), 8'd1);
		bus_write(CART_RAM_LO, 8'h3C);
		check("cart_wr", data_t'(wr_cart_seen), 8'd1);
		check("cart_addr hi", wr_cart_addr[15:8], 8'hA0);
		check("cart_addr lo", wr_cart_addr[7:0], 8'h00);
		check("cart_wdata", wr_cart_data, 8'h3C);
		@(negedge clk_cpu);
		check("cart_wr idle", data_t'(cart_wr), 8'd0);
	endtask

	initial begin
		void'($urandom(17));
		reset       <= 1'b1;
		is_gbc      <= 1'b1;          // colour mode for the whole run
		irq_ack     <= 1'b0;
		irq_src_ext <= 4'b0000;
		keys        <= 8'h00;
		cpu_bus     <= '0;
		repeat (3) @(posedge clk_cpu);
		reset <= 1'b0;
		after_reset_state;
		ram_readback;
		irq_priority;
		joypad_matrix;
		boot_overlay_steer;
		$display("all tests passed");
		$finish;
	end

endmodule

// File: project.f
gb_pkg.sv
gb_bus_map.sv
gb_irq_ctrl.sv
gb_joypad.sv
gb_wram.sv
gb_boot_overlay.sv
gb_sys_bus.sv
tb_gb_sys_bus.sv

// File: Makefile
SRCS := $(shell cat project.f)

obj_dir/Vtb_gb_sys_bus: $(SRCS) project.f
	verilator --binary --timing -f project.f --top-module tb_gb_sys_bus -o Vtb_gb_sys_bus

run: obj_dir/Vtb_gb_sys_bus
	./obj_dir/Vtb_gb_sys_bus | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
